// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tetris_top.f \
		--top-module tetris_tb -o tetris_sim
	./obj_dir/tetris_sim | tee sim.log
	grep -q "^RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/button_edge.sv
module button_edge (
    input  logic clk,
    input  logic reset,
    input  logic in_i,
    output logic pulse_o
);

    // two-stage synchronizer, then a history flop for the edge
    logic sync0_q;
    logic sync1_q;
    logic hist_q;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            sync0_q <= 1'b0;
            sync1_q <= 1'b0;
            hist_q  <= 1'b0;
        end else begin
            sync0_q <= in_i;
            sync1_q <= sync0_q;
            hist_q  <= sync1_q;
        end
    end

    // high for the one cycle where the synced level has just risen
    assign pulse_o = sync1_q & ~hist_q;

endmodule

// File: hdl/game_fsm.sv
module game_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start_i,
    input  logic                 drop_i,
    input  tetris_pkg::collide_t collide_i,
    input  logic                 top_filled_i,
    input  logic                 clear_done_i,
    output logic                 spawn_o,
    output logic                 falling_o,
    output logic                 lock_o,
    output logic                 clear_start_o,
    output logic                 gameover_o
);

    typedef enum logic [2:0] {
        IDLE,
        SPAWN,
        FALLING,
        LOCK,
        CHECK,
        CLEAR,
        OVER
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ============================================================
    // next state
    // ============================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // start is a level, no edge needed
                if (start_i) begin
                    state_d = SPAWN;
                end
            end
            SPAWN: begin
                state_d = FALLING;
            end
            FALLING: begin
                // lock on the first tick that finds the piece resting
                if (drop_i && collide_i.bottom) begin
                    state_d = LOCK;
                end
            end
            LOCK: begin
                state_d = CHECK;
            end
            CHECK: begin
                if (top_filled_i) begin
                    state_d = OVER;
                end else begin
                    state_d = CLEAR;
                end
            end
            CLEAR: begin
                if (clear_done_i) begin
                    state_d = SPAWN;
                end
            end
            OVER: begin
                // held until reset
                state_d = OVER;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // strobes straight from the state
    assign spawn_o       = (state_q == SPAWN);
    assign falling_o     = (state_q == FALLING);
    assign lock_o        = (state_q == LOCK);
    assign clear_start_o = (state_q == CHECK) && !top_filled_i;
    assign gameover_o    = (state_q == OVER);

endmodule

// File: hdl/piece_mover.sv
module piece_mover (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   spawn_i,
    input  logic                   falling_i,
    input  tetris_pkg::move_req_t  move_i,
    input  tetris_pkg::board_t     stored_i,
    output tetris_pkg::piece_pos_t pos_o,
    output tetris_pkg::board_t     overlay_o,
    output tetris_pkg::collide_t   collide_o
);

    tetris_pkg::piece_pos_t  pos_q;
    // code handed out on the next spawn
    tetris_pkg::piece_code_t next_code_q;
    tetris_pkg::pattern_t    pattern;

    piece_rom i_rom (
        .code_i    (pos_q.code),
        .pattern_o (pattern)
    );

    // ============================================================
    // position register
    // ============================================================
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pos_q.code  <= '0;
            pos_q.row   <= '0;
            pos_q.col   <= tetris_pkg::SPAWN_COL;
            next_code_q <= '0;
        end else if (spawn_i) begin
            pos_q.code <= next_code_q;
            pos_q.row  <= '0;
            pos_q.col  <= tetris_pkg::SPAWN_COL;
            // fixed cyclic order I O S Z J L T
            if (next_code_q == tetris_pkg::piece_code_t'(tetris_pkg::NUM_PIECES - 1)) begin
                next_code_q <= '0;
            end else begin
                next_code_q <= next_code_q + 3'd1;
            end
        end else if (falling_i) begin
            // drop and sideways move may land in the same cycle
            if (move_i.drop && !collide_o.bottom) begin
                pos_q.row <= pos_q.row + 5'd1;
            end
            // left wins over right
            if (move_i.left && !collide_o.left) begin
                pos_q.col <= pos_q.col - 4'd1;
            end else if (move_i.right && !collide_o.right) begin
                pos_q.col <= pos_q.col + 4'd1;
            end
        end
    end

    assign pos_o = pos_q;

    // ============================================================
    // overlay and collision
    // ============================================================
    always_comb begin
        int ar;
        int ac;
        overlay_o = '0;
        collide_o = '0;
        ar = 0;
        ac = 0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                ar = int'(pos_q.row) + r;
                ac = int'(pos_q.col) + c;
                // a cell of the piece, always inside the board
                if (pattern[r][c] && ar < tetris_pkg::BOARD_ROWS
                        && ac < tetris_pkg::BOARD_COLS) begin
                    overlay_o[ar][ac] = 1'b1;
                    // floor or stack right below
                    if (ar + 1 >= tetris_pkg::BOARD_ROWS) begin
                        collide_o.bottom = 1'b1;
                    end else if (stored_i[ar+1][ac]) begin
                        collide_o.bottom = 1'b1;
                    end
                    // left wall or stack to the left
                    if (ac == 0) begin
                        collide_o.left = 1'b1;
                    end else if (stored_i[ar][ac-1]) begin
                        collide_o.left = 1'b1;
                    end
                    // right wall or stack to the right
                    if (ac + 1 >= tetris_pkg::BOARD_COLS) begin
                        collide_o.right = 1'b1;
                    end else if (stored_i[ar][ac+1]) begin
                        collide_o.right = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: hdl/piece_rom.sv
module piece_rom (
    input  tetris_pkg::piece_code_t code_i,
    output tetris_pkg::pattern_t    pattern_o
);

    // code to 4x4 occupancy, shapes live in the package
    always_comb begin
        case (code_i)
            tetris_pkg::PIECE_I: begin
                pattern_o = tetris_pkg::SHAPE_I;
            end
            tetris_pkg::PIECE_O: begin
                pattern_o = tetris_pkg::SHAPE_O;
            end
            tetris_pkg::PIECE_S: begin
                pattern_o = tetris_pkg::SHAPE_S;
            end
            tetris_pkg::PIECE_Z: begin
                pattern_o = tetris_pkg::SHAPE_Z;
            end
            tetris_pkg::PIECE_J: begin
                pattern_o = tetris_pkg::SHAPE_J;
            end
            tetris_pkg::PIECE_L: begin
                pattern_o = tetris_pkg::SHAPE_L;
            end
            tetris_pkg::PIECE_T: begin
                pattern_o = tetris_pkg::SHAPE_T;
            end
            default: begin
                // code 7 is unused, shows nothing
                pattern_o = '0;
            end
        endcase
    end

endmodule

// File: hdl/playfield.sv
module playfield (
    input  logic               clk,
    input  logic               reset,
    input  logic               lock_i,
    input  logic               clear_start_i,
    input  tetris_pkg::board_t overlay_i,
    input  logic               falling_i,
    output tetris_pkg::board_t stored_o,
    output logic               top_filled_o,
    output logic               clear_done_o,
    output logic [9:0]         score_o,
    output tetris_pkg::board_t display_o
);

    tetris_pkg::board_t stored_q;

    // scanner state
    logic [4:0] scan_row_q;
    logic       scan_busy_q;
    // set for the one shift cycle after a full row is seen
    logic       shift_q;
    logic [9:0] score_q;

    tetris_pkg::row_t scan_word;
    logic             row_full;

    assign scan_word = stored_q[scan_row_q];
    assign row_full  = &scan_word;

    // ============================================================
    // stored board
    // ============================================================
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            stored_q <= '0;
        end else if (lock_i) begin
            // merge the falling piece
            stored_q <= stored_q | overlay_i;
        end else if (shift_q) begin
            // everything above the full row moves down one
            for (int r = tetris_pkg::BOARD_ROWS - 1; r > 0; r--) begin
                if (r <= int'(scan_row_q)) begin
                    stored_q[r] <= stored_q[r-1];
                end
            end
            stored_q[0] <= '0;
        end
    end

    // ============================================================
    // row-clear scanner
    // ============================================================
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            scan_row_q  <= '0;
            scan_busy_q <= 1'b0;
            shift_q     <= 1'b0;
            score_q     <= '0;
        end else if (clear_start_i) begin
            // bottom row first
            scan_row_q  <= 5'(tetris_pkg::BOARD_ROWS - 1);
            scan_busy_q <= 1'b1;
            shift_q     <= 1'b0;
        end else if (scan_busy_q) begin
            if (shift_q) begin
                // same row is scanned again after the shift
                shift_q <= 1'b0;
                score_q <= score_q + 10'd1;
            end else if (row_full) begin
                shift_q <= 1'b1;
            end else if (scan_row_q == 5'd0) begin
                scan_busy_q <= 1'b0;
            end else begin
                scan_row_q <= scan_row_q - 5'd1;
            end
        end
    end

    // last row passed without a shift
    assign clear_done_o = scan_busy_q && !shift_q && !row_full && (scan_row_q == 5'd0);

    // ============================================================
    // outputs
    // ============================================================
    assign stored_o     = stored_q;
    assign top_filled_o = |stored_q[0];
    assign score_o      = score_q;

    // piece shown only while it is falling
    assign display_o = falling_i ? (stored_q | overlay_i) : stored_q;

endmodule

// File: hdl/tetris_pkg.sv
package tetris_pkg;

    // ============================================================
    // board geometry
    // ============================================================
    localparam int BOARD_ROWS = 20;
    localparam int BOARD_COLS = 10;
    localparam int NUM_PIECES = 7;
    // left edge of the 4x4 box for a new piece
    localparam logic [3:0] SPAWN_COL = 4'd3;

    // row 0 at the top, bit c of a row is column c
    typedef logic [BOARD_COLS-1:0] row_t;
    typedef logic [BOARD_ROWS-1:0][BOARD_COLS-1:0] board_t;

    // ============================================================
    // pieces
    // ============================================================
    typedef logic [2:0] piece_code_t;

    localparam piece_code_t PIECE_I = 3'd0;
    localparam piece_code_t PIECE_O = 3'd1;
    localparam piece_code_t PIECE_S = 3'd2;
    localparam piece_code_t PIECE_Z = 3'd3;
    localparam piece_code_t PIECE_J = 3'd4;
    localparam piece_code_t PIECE_L = 3'd5;
    localparam piece_code_t PIECE_T = 3'd6;

    // indexed [box row][box col], so each hex digit is one box row
    // with row 0 in the lowest digit and col 0 in the lowest bit
    typedef logic [3:0][3:0] pattern_t;

    localparam pattern_t SHAPE_I = 16'h1111;
    localparam pattern_t SHAPE_O = 16'h0033;
    localparam pattern_t SHAPE_S = 16'h0036;
    localparam pattern_t SHAPE_Z = 16'h0063;
    localparam pattern_t SHAPE_J = 16'h0322;
    localparam pattern_t SHAPE_L = 16'h0311;
    localparam pattern_t SHAPE_T = 16'h0027;

    // ============================================================
    // shared bundles
    // ============================================================
    typedef struct packed {
        piece_code_t code;
        logic [4:0] row;
        logic [3:0] col;
    } piece_pos_t;

    // single-cycle pulses from the button side
    typedef struct packed {
        logic left;
        logic right;
        logic drop;
    } move_req_t;

    typedef struct packed {
        logic bottom;
        logic left;
        logic right;
    } collide_t;

endpackage

// File: hdl/tetris_top.sv
module tetris_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               start_i,
    input  logic               left_i,
    input  logic               right_i,
    input  logic               drop_tick_i,
    output tetris_pkg::board_t display_o,
    output logic [9:0]         score_o,
    output logic               gameover_o
);

    // ============================================================
    // input side
    // ============================================================
    tetris_pkg::move_req_t move_req;

    button_edge i_left_edge (
        .clk     (clk),
        .reset   (reset),
        .in_i    (left_i),
        .pulse_o (move_req.left)
    );

    button_edge i_right_edge (
        .clk     (clk),
        .reset   (reset),
        .in_i    (right_i),
        .pulse_o (move_req.right)
    );

    // drop tick treated like a button
    button_edge i_drop_edge (
        .clk     (clk),
        .reset   (reset),
        .in_i    (drop_tick_i),
        .pulse_o (move_req.drop)
    );

    // ============================================================
    // processing
    // ============================================================
    logic                   spawn;
    logic                   falling;
    logic                   lock;
    logic                   clear_start;
    logic                   clear_done;
    logic                   top_filled;
    tetris_pkg::collide_t   collide;
    tetris_pkg::board_t     overlay;
    tetris_pkg::board_t     stored;

    piece_mover i_mover (
        .clk       (clk),
        .reset     (reset),
        .spawn_i   (spawn),
        .falling_i (falling),
        .move_i    (move_req),
        .stored_i  (stored),
        .pos_o     (),
        .overlay_o (overlay),
        .collide_o (collide)
    );

    // drop pulse also goes here to trigger the lock
    game_fsm i_fsm (
        .clk           (clk),
        .reset         (reset),
        .start_i       (start_i),
        .drop_i        (move_req.drop),
        .collide_i     (collide),
        .top_filled_i  (top_filled),
        .clear_done_i  (clear_done),
        .spawn_o       (spawn),
        .falling_o     (falling),
        .lock_o        (lock),
        .clear_start_o (clear_start),
        .gameover_o    (gameover_o)
    );

    // ============================================================
    // output side
    // ============================================================
    playfield i_playfield (
        .clk           (clk),
        .reset         (reset),
        .lock_i        (lock),
        .clear_start_i (clear_start),
        .overlay_i     (overlay),
        .falling_i     (falling),
        .stored_o      (stored),
        .top_filled_o  (top_filled),
        .clear_done_o  (clear_done),
        .score_o       (score_o),
        .display_o     (display_o)
    );

endmodule

// File: tetris_top.f
hdl/tetris_pkg.sv
hdl/button_edge.sv
hdl/piece_rom.sv
hdl/piece_mover.sv
hdl/game_fsm.sv
hdl/playfield.sv
hdl/tetris_top.sv
verif/tetris_chk.sv
verif/tetris_tb.sv

// File: verif/tetris_chk.sv
module tetris_chk (
    input logic       clk,
    input logic       reset,
    input logic       gameover_i,
    input logic       spawn_i,
    input logic       top_filled_i,
    input logic [9:0] score_i
);

    // count of failed properties
    int fail_count = 0;

    // ============================================================
    // game over is sticky until reset
    // ============================================================
    gameover_sticky: assert property (@(posedge clk) disable iff (reset)
        gameover_i |=> gameover_i)
        else begin
            fail_count++;
            $error("gameover_o fell without reset");
        end

    // a piece only enters with an empty top row
    spawn_top_clear: assert property (@(posedge clk) disable iff (reset)
        spawn_i |-> !top_filled_i)
        else begin
            fail_count++;
            $error("spawn strobe while row 0 is occupied");
        end

    // one cleared row per step, 10-bit wrap
    score_step: assert property (@(posedge clk) disable iff (reset)
        $changed(score_i) |-> (score_i == $past(score_i) + 10'd1))
        else begin
            fail_count++;
            $error("score_o changed by something other than +1");
        end

endmodule

bind tetris_top tetris_chk i_chk (
    .clk          (clk),
    .reset        (reset),
    .gameover_i   (gameover_o),
    .spawn_i      (spawn),
    .top_filled_i (top_filled),
    .score_i      (score_o)
);

// File: verif/tetris_tb.sv
module tetris_tb;

    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_START,
        ACT_LEFT,
        ACT_RIGHT,
        ACT_TICK
    } action_t;

    // one table row: action, repeats, then expected values
    typedef struct packed {
        action_t     act;
        logic [8:0]  count;
        logic        row_en;
        logic [4:0]  row;
        logic [9:0]  row_val;
        logic [9:0]  score;
        logic        over;
    } step_t;

    logic               clk;
    logic               reset;
    logic               start_i;
    logic               left_i;
    logic               right_i;
    logic               drop_tick_i;
    tetris_pkg::board_t display_o;
    logic [9:0]         score_o;
    logic               gameover_o;

    step_t       steps[$];
    logic [15:0] lfsr_q;
    int          errors;
    int          timeouts;
    int          assert_fails;

    tetris_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .start_i     (start_i),
        .left_i      (left_i),
        .right_i     (right_i),
        .drop_tick_i (drop_tick_i),
        .display_o   (display_o),
        .score_o     (score_o),
        .gameover_o  (gameover_o)
    );

    always #50 clk = ~clk;

    // ============================================================
    // helpers
    // ============================================================
    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // 0..7 idle cycles, one lfsr step per bit
    task automatic take_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 3; b++) begin
            gap = (gap << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic set_input(input action_t act, input logic v);
        case (act)
            ACT_START: start_i = v;
            ACT_LEFT:  left_i = v;
            ACT_RIGHT: right_i = v;
            ACT_TICK:  drop_tick_i = v;
            default: begin
            end
        endcase
    endtask

    // held high 4 cycles, then a random idle gap
    task automatic press(input action_t act);
        int gap;
        @(posedge clk);
        #10;
        set_input(act, 1'b1);
        repeat (4) @(posedge clk);
        #10;
        set_input(act, 1'b0);
        take_gap(gap);
        repeat (gap) @(posedge clk);
    endtask

    // stable for longer than a full clear pass
    task automatic wait_settle();
        tetris_pkg::board_t last;
        int stable;
        int cycles;
        last = display_o;
        stable = 0;
        cycles = 0;
        while (stable < 32 && cycles < 600) begin
            @(negedge clk);
            cycles++;
            if (display_o === last) begin
                stable++;
            end else begin
                stable = 0;
                last = display_o;
            end
        end
        if (stable < 32) begin
            timeouts++;
            $display("timeout at %0t: display did not settle within 600 cycles", $time);
        end
    endtask

    task automatic add_step(input action_t act, input int count, input logic row_en,
                            input int row, input logic [9:0] row_val,
                            input int score, input logic over);
        step_t s;
        s.act = act;
        s.count = 9'(count);
        s.row_en = row_en;
        s.row = 5'(row);
        s.row_val = row_val;
        s.score = 10'(score);
        s.over = over;
        steps.push_back(s);
    endtask

    // ============================================================
    // step table
    // ============================================================
    task automatic build_table();
        add_step(ACT_START, 1, 1, 0, 10'h008, 0, 0);
        add_step(ACT_NONE, 1, 1, 3, 10'h008, 0, 0);
        // I to col 7 and down
        add_step(ACT_RIGHT, 4, 1, 0, 10'h080, 0, 0);
        add_step(ACT_TICK, 4, 1, 4, 10'h080, 0, 0);
        add_step(ACT_TICK, 12, 1, 19, 10'h080, 0, 0);
        add_step(ACT_TICK, 1, 1, 0, 10'h018, 0, 0);
        // O against the right wall, one extra press
        add_step(ACT_RIGHT, 6, 1, 0, 10'h300, 0, 0);
        add_step(ACT_TICK, 18, 1, 19, 10'h380, 0, 0);
        add_step(ACT_TICK, 1, 1, 0, 10'h030, 0, 0);
        // S and Z parked on top of I and O
        add_step(ACT_RIGHT, 4, 1, 0, 10'h300, 0, 0);
        add_step(ACT_TICK, 15, 1, 0, 10'h018, 0, 0);
        add_step(ACT_RIGHT, 4, 1, 0, 10'h180, 0, 0);
        add_step(ACT_TICK, 13, 1, 0, 10'h010, 0, 0);
        // J at the left wall
        add_step(ACT_LEFT, 3, 1, 0, 10'h002, 0, 0);
        add_step(ACT_TICK, 18, 1, 0, 10'h008, 0, 0);
        add_step(ACT_NONE, 1, 1, 19, 10'h383, 0, 0);
        // L at col 2
        add_step(ACT_LEFT, 1, 1, 0, 10'h004, 0, 0);
        add_step(ACT_TICK, 18, 1, 0, 10'h038, 0, 0);
        add_step(ACT_NONE, 1, 1, 19, 10'h38f, 0, 0);
        // T past the left wall, lands on J and L
        add_step(ACT_LEFT, 4, 1, 0, 10'h007, 0, 0);
        add_step(ACT_TICK, 16, 1, 0, 10'h008, 0, 0);
        add_step(ACT_RIGHT, 1, 1, 0, 10'h010, 0, 0);
        add_step(ACT_TICK, 17, 1, 0, 10'h018, 0, 0);
        add_step(ACT_NONE, 1, 1, 19, 10'h39f, 0, 0);
        // O closes row 19, old row 18 drops in
        add_step(ACT_RIGHT, 2, 1, 0, 10'h060, 0, 0);
        add_step(ACT_TICK, 19, 1, 0, 10'h030, 1, 0);
        add_step(ACT_NONE, 1, 1, 19, 10'h3f6, 1, 0);
        // stack in the middle until the top fills
        add_step(ACT_TICK, 250, 0, 0, 10'h000, 1, 1);
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        tetris_pkg::board_t frozen;
        clk = 1'b0;
        reset = 1'b1;
        start_i = 1'b0;
        left_i = 1'b0;
        right_i = 1'b0;
        drop_tick_i = 1'b0;
        lfsr_q = 16'd58760;
        errors = 0;
        timeouts = 0;
        assert_fails = 0;
        build_table();
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b0;

        @(negedge clk);
        check_value(display_o, '0, "board after reset");
        check_value(score_o, 0, "score after reset");
        check_value(gameover_o, 0, "gameover after reset");

        foreach (steps[i]) begin
            for (int n = 0; n < int'(steps[i].count) && timeouts == 0; n++) begin
                if (steps[i].act != ACT_NONE) begin
                    press(steps[i].act);
                end
                wait_settle();
            end
            if (timeouts == 0) begin
                if (steps[i].row_en) begin
                    check_value(display_o[steps[i].row], steps[i].row_val,
                                $sformatf("step %0d row %0d", i, steps[i].row));
                end
                check_value(score_o, steps[i].score, $sformatf("step %0d score", i));
                check_value(gameover_o, steps[i].over, $sformatf("step %0d gameover", i));
            end
        end

        // board frozen once the game is over
        if (timeouts == 0) begin
            frozen = display_o;
            press(ACT_LEFT);
            press(ACT_RIGHT);
            press(ACT_TICK);
            wait_settle();
            check_value(display_o, frozen, "board after game over");
            check_value(gameover_o, 1, "gameover held");
        end

        assert_fails = i_dut.i_chk.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
